/* design/calcLayoutPkg.sv */
package calcLayoutPkg;

	// Pointer coordinate widths from the mouse block
	localparam int xWidth = 10;
	localparam int yWidth = 9;

	////////////////////////////////////////////////////////////
	// Keypad placement on the 640x480 screen
	////////////////////////////////////////////////////////////

	// Top left corner of the first square
	localparam int defaultOriginX = 175;
	localparam int defaultOriginY = 190;

	// Squares are this many pixels wide and tall
	localparam int defaultCellSize = 63;

	// Grid of squares, some of them blank
	localparam int keyCols = 5;
	localparam int keyRows = 4;

endpackage

/* design/calcKeyPkg.sv */
package calcKeyPkg;

	// Signed arithmetic width
	localparam int valueWidth = 16;

	// Enough decimal digits for the magnitude of any 16 bit result
	localparam int bcdDigitCount = 5;

	// Longest operand the user can type
	localparam int maxEntryDigits = 4;

	////////////////////////////////////////////////////////////
	// Key encoding
	////////////////////////////////////////////////////////////

	// Operator codes sit above the digit range 0 to 9
	typedef enum logic [3:0] {
		opAdd    = 4'd10,
		opSub    = 4'd11,
		opMul    = 4'd12,
		opDiv    = 4'd13,
		opEquals = 4'd14,
		opNone   = 4'd15    // pending state only, never sent as a key
	} calcOpT;

	// One nibble, read as a digit or as an operator
	typedef union packed {
		logic [3:0] digit;
		calcOpT     op;
	} keyCodeT;

endpackage

/* design/keyIf.sv */
`timescale 1ns/10ps

interface keyIf;
	import calcKeyPkg::*;

	logic    valid;
	logic    isDigit;
	logic    isOp;
	keyCodeT key;

	// Decode side
	modport decoder (output valid, output isDigit, output isOp, output key);

	// Execute side
	modport executor (input valid, input isDigit, input isOp, input key);

endinterface

/* design/resultIf.sv */
`timescale 1ns/10ps

interface resultIf #(
	parameter int valueBits = calcKeyPkg::valueWidth
);

	logic                        valid;
	logic signed [valueBits-1:0] value;
	logic                        overflow;
	logic                        divByZero;

	// Execute side
	modport producer (output valid, output value, output overflow, output divByZero);

	// BCD conversion side
	modport consumer (input valid, input value, input overflow, input divByZero);

endinterface

/* design/clickDecoder.sv */
`timescale 1ns/10ps

module clickDecoder #(
	parameter int originX  = calcLayoutPkg::defaultOriginX,
	parameter int originY  = calcLayoutPkg::defaultOriginY,
	parameter int cellSize = calcLayoutPkg::defaultCellSize
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [2:0]                       clicked,
	input  logic [calcLayoutPkg::xWidth-1:0] xLocation,
	input  logic [calcLayoutPkg::yWidth-1:0] yLocation,
	keyIf.decoder                            keys
);
	import calcLayoutPkg::*;
	import calcKeyPkg::*;

	localparam int colBits = $clog2(keyCols);
	localparam int rowBits = $clog2(keyRows);

	logic               pressed;
	logic               wasPressed;
	logic               pressEdge;
	logic               colHit;
	logic               rowHit;
	logic [colBits-1:0] colIdx;
	logic [rowBits-1:0] rowIdx;
	logic               hitDigit;
	logic               hitOp;
	keyCodeT            hitCode;

	assign pressed   = |clicked;
	assign pressEdge = pressed && !wasPressed;

	////////////////////////////////////////////////////////////
	// Which square is under the pointer
	////////////////////////////////////////////////////////////

	// Strict bounds so a pixel on a square's border hits nothing
	always_comb
	begin
		colHit = 1'b0;
		colIdx = '0;
		rowHit = 1'b0;
		rowIdx = '0;
		for (int c = 0; c < keyCols; c++)
		begin
			if (int'(xLocation) > originX + c * cellSize &&
				int'(xLocation) < originX + (c + 1) * cellSize)
			begin
				colHit = 1'b1;
				colIdx = colBits'(c);
			end
		end
		for (int r = 0; r < keyRows; r++)
		begin
			if (int'(yLocation) > originY + r * cellSize &&
				int'(yLocation) < originY + (r + 1) * cellSize)
			begin
				rowHit = 1'b1;
				rowIdx = rowBits'(r);
			end
		end
	end

	// Square to key code
	always_comb
	begin
		hitDigit = 1'b0;
		hitOp    = 1'b0;
		hitCode  = '0;
		if (colHit && rowHit)
		begin
			if (colIdx < 3 && rowIdx < 3)
			begin
				// Digits 7 8 9 on top down to 1 2 3
				hitDigit      = 1'b1;
				hitCode.digit = 4'((2 - int'(rowIdx)) * 3 + int'(colIdx) + 1);
			end
			else if (rowIdx == 3 && colIdx == 0)
			begin
				hitDigit      = 1'b1;
				hitCode.digit = 4'd0;
			end
			else if (colIdx == 3 && rowIdx < 2)
			begin
				hitOp      = 1'b1;
				hitCode.op = (rowIdx == 0) ? opMul : opAdd;
			end
			else if (colIdx == 4)
			begin
				hitOp = 1'b1;
				case (rowIdx)
					0: hitCode.op = opDiv;
					1: hitCode.op = opSub;
					2: hitCode.op = opEquals;
					default: hitOp = 1'b0;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// One key event per press
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wasPressed   <= 1'b0;
			keys.valid   <= 1'b0;
			keys.isDigit <= 1'b0;
			keys.isOp    <= 1'b0;
		end
		else
		begin
			wasPressed   <= pressed;
			keys.valid   <= pressEdge && (hitDigit || hitOp);
			keys.isDigit <= pressEdge && hitDigit;
			keys.isOp    <= pressEdge && hitOp;
		end
	end

	always_ff @(posedge clk)
	begin
		if (pressEdge)
			keys.key <= hitCode;
	end

	keyKindExclusive: assert property (@(posedge clk) disable iff (rst)
		!(keys.isDigit && keys.isOp));

endmodule

/* design/calcExecute.sv */
`timescale 1ns/10ps

module calcExecute #(
	parameter int valueBits = calcKeyPkg::valueWidth
) (
	input  logic       clk,
	input  logic       rst,
	keyIf.executor     keys,
	resultIf.producer  results
);
	import calcKeyPkg::*;

	localparam int wideBits  = 2 * valueBits;
	localparam int countBits = $clog2(maxEntryDigits + 1);

	logic signed [valueBits-1:0] entry;
	logic        [countBits-1:0] entryDigits;
	logic signed [valueBits-1:0] acc;
	calcOpT                      pendingOp;
	logic                        errOverflow;
	logic                        errDivZero;

	logic signed [wideBits-1:0]  accWide;
	logic signed [wideBits-1:0]  entryWide;
	logic signed [wideBits-1:0]  stepWide;
	logic                        stepOverflow;
	logic                        stepDivZero;
	logic                        equalsKey;

	assign equalsKey = keys.valid && keys.isOp && keys.key.op == opEquals;

	////////////////////////////////////////////////////////////
	// Pending operation on accumulator and entry
	////////////////////////////////////////////////////////////

	// Double width so the range check sees the true result
	always_comb
	begin
		accWide     = acc;
		entryWide   = entry;
		stepDivZero = 1'b0;
		case (pendingOp)
			opAdd: stepWide = accWide + entryWide;
			opSub: stepWide = accWide - entryWide;
			opMul: stepWide = accWide * entryWide;
			opDiv:
			begin
				if (entry == '0)
				begin
					stepDivZero = 1'b1;
					stepWide    = '0;
				end
				else
					stepWide = accWide / entryWide;
			end
			default: stepWide = entryWide;    // first operand
		endcase
		// Upper bits must all copy the sign bit
		stepOverflow = !((&stepWide[wideBits-1:valueBits-1]) ||
			!(|stepWide[wideBits-1:valueBits-1]));
	end

	////////////////////////////////////////////////////////////
	// Entry and operator state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			entry         <= '0;
			entryDigits   <= '0;
			acc           <= '0;
			pendingOp     <= opNone;
			errOverflow   <= 1'b0;
			errDivZero    <= 1'b0;
			results.valid <= 1'b0;
		end
		else
		begin
			results.valid <= equalsKey;
			if (keys.valid && keys.isDigit)
			begin
				// Extra digits past the limit are dropped
				if (entryDigits < maxEntryDigits)
				begin
					entry       <= valueBits'(entry * 10 + int'(keys.key.digit));
					entryDigits <= entryDigits + 1'b1;
				end
			end
			else if (keys.valid && keys.isOp)
			begin
				entry       <= '0;
				entryDigits <= '0;
				if (equalsKey)
				begin
					acc         <= '0;
					pendingOp   <= opNone;
					errOverflow <= 1'b0;
					errDivZero  <= 1'b0;
				end
				else
				begin
					acc         <= stepWide[valueBits-1:0];
					pendingOp   <= keys.key.op;
					errOverflow <= errOverflow || stepOverflow;
					errDivZero  <= errDivZero || stepDivZero;
				end
			end
		end
	end

	// Result word and flags, sampled downstream with valid
	always_ff @(posedge clk)
	begin
		if (equalsKey)
		begin
			results.value     <= stepWide[valueBits-1:0];
			results.overflow  <= errOverflow || stepOverflow;
			results.divByZero <= errDivZero || stepDivZero;
		end
	end

	resultOnlyAfterEquals: assert property (@(posedge clk) disable iff (rst)
		results.valid |-> $past(keys.valid && keys.isOp && keys.key.op == opEquals));

endmodule

/* design/bcdConverter.sv */
`timescale 1ns/10ps

module bcdConverter #(
	parameter int valueBits = calcKeyPkg::valueWidth
) (
	input  logic                                   clk,
	input  logic                                   rst,
	resultIf.consumer                              results,
	output logic [4*calcKeyPkg::bcdDigitCount-1:0] bcdDigits,
	output logic                                   negative,
	output logic                                   error,
	output logic                                   displayValid
);
	import calcKeyPkg::*;

	localparam int bcdBits   = 4 * bcdDigitCount;
	localparam int countBits = $clog2(valueBits + 1);

	logic                 busy;
	logic [countBits-1:0] bitsLeft;
	logic [valueBits-1:0] binaryWork;
	logic [bcdBits-1:0]   bcdWork;
	logic [bcdBits-1:0]   bcdAdjusted;
	logic                 signLatched;
	logic                 errorLatched;

	// Add 3 to every digit of 5 or more before the next shift
	always_comb
	begin
		bcdAdjusted = bcdWork;
		for (int d = 0; d < bcdDigitCount; d++)
		begin
			if (bcdWork[4*d +: 4] >= 4'd5)
				bcdAdjusted[4*d +: 4] = bcdWork[4*d +: 4] + 4'd3;
		end
	end

	////////////////////////////////////////////////////////////
	// Latch, shift valueBits times, then present
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy         <= 1'b0;
			bitsLeft     <= '0;
			bcdDigits    <= '0;
			negative     <= 1'b0;
			error        <= 1'b0;
			displayValid <= 1'b0;
		end
		else
		begin
			displayValid <= 1'b0;
			if (results.valid)
			begin
				// A new result replaces any conversion in flight
				busy     <= 1'b1;
				bitsLeft <= countBits'(valueBits);
			end
			else if (busy && bitsLeft != '0)
				bitsLeft <= bitsLeft - 1'b1;
			else if (busy)
			begin
				busy         <= 1'b0;
				bcdDigits    <= errorLatched ? '0 : bcdWork;
				negative     <= signLatched && !errorLatched;
				error        <= errorLatched;
				displayValid <= 1'b1;
			end
		end
	end

	// Datapath
	always_ff @(posedge clk)
	begin
		if (results.valid)
		begin
			binaryWork   <= results.value[valueBits-1] ?
				valueBits'(-results.value) : results.value;
			bcdWork      <= '0;
			signLatched  <= results.value[valueBits-1];
			errorLatched <= results.overflow || results.divByZero;
		end
		else if (busy && bitsLeft != '0)
		begin
			bcdWork    <= {bcdAdjusted[bcdBits-2:0], binaryWork[valueBits-1]};
			binaryWork <= {binaryWork[valueBits-2:0], 1'b0};
		end
	end

	singleDisplayPulse: assert property (@(posedge clk) disable iff (rst)
		displayValid |=> !displayValid);

endmodule

/* design/mouseCalculator.sv */
`timescale 1ns/10ps

module mouseCalculator #(
	parameter int originX   = calcLayoutPkg::defaultOriginX,
	parameter int originY   = calcLayoutPkg::defaultOriginY,
	parameter int cellSize  = calcLayoutPkg::defaultCellSize,
	parameter int valueBits = calcKeyPkg::valueWidth
) (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic [2:0]                             clicked,
	input  logic [calcLayoutPkg::xWidth-1:0]       xLocation,
	input  logic [calcLayoutPkg::yWidth-1:0]       yLocation,
	output logic [4*calcKeyPkg::bcdDigitCount-1:0] bcdDigits,
	output logic                                   negative,
	output logic                                   error,
	output logic                                   displayValid
);

	keyIf                               keyBus ();
	resultIf #(.valueBits(valueBits))   resultBus ();

	// Mouse press to key event
	clickDecoder #(
		.originX  (originX),
		.originY  (originY),
		.cellSize (cellSize)
	) i_clickDecoder (
		.clk       (clk),
		.rst       (rst),
		.clicked   (clicked),
		.xLocation (xLocation),
		.yLocation (yLocation),
		.keys      (keyBus.decoder)
	);

	calcExecute #(.valueBits(valueBits)) i_calcExecute (
		.clk     (clk),
		.rst     (rst),
		.keys    (keyBus.executor),
		.results (resultBus.producer)
	);

	// Result to display digits
	bcdConverter #(.valueBits(valueBits)) i_bcdConverter (
		.clk          (clk),
		.rst          (rst),
		.results      (resultBus.consumer),
		.bcdDigits    (bcdDigits),
		.negative     (negative),
		.error        (error),
		.displayValid (displayValid)
	);

endmodule

/* tb/tbMouseCalculator.sv */
`timescale 1ns/10ps

module tbMouseCalculator;
	import calcLayoutPkg::*;
	import calcKeyPkg::*;

	localparam int holdCycles  = 30;
	localparam int maxValue    = (1 << (valueWidth - 1)) - 1;
	localparam int minValue    = -maxValue - 1;
	// Worst case presses and results over all tests
	localparam int pressCount  = 270;
	localparam int resultCount = 31;
	localparam int cycleLimit  = pressCount * 6 + resultCount * (valueWidth + 10) + 300;

	logic                         clk = 1'b0;
	logic                         rst = 1'b1;
	logic [2:0]                   clicked = 3'b000;
	logic [xWidth-1:0]            xLocation = '0;
	logic [yWidth-1:0]            yLocation = '0;
	logic [4*bcdDigitCount-1:0]   bcdDigits;
	logic                         negative;
	logic                         error;
	logic                         displayValid;

	int          cycleCount = 0;
	logic [31:0] lcgState = 32'd46232;

	// Reference model state
	int   modelEntry = 0;
	int   modelDigits = 0;
	int   modelAcc = 0;
	byte  modelOp = " ";
	logic modelOverflow = 1'b0;
	logic modelDivZero = 1'b0;
	int   lastValue = 0;
	logic lastError = 1'b0;

	mouseCalculator i_mouseCalculator (
		.clk          (clk),
		.rst          (rst),
		.clicked      (clicked),
		.xLocation    (xLocation),
		.yLocation    (yLocation),
		.bcdDigits    (bcdDigits),
		.negative     (negative),
		.error        (error),
		.displayValid (displayValid)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
			failRun($sformatf("timeout after %0d cycles, the display never updated", cycleCount));
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1, "stopping at first error");
	endtask

	function automatic int unsigned nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return {17'd0, lcgState[30:16]};
	endfunction

	function automatic int centreX(input int col);
		return defaultOriginX + col * defaultCellSize + defaultCellSize / 2;
	endfunction

	function automatic int centreY(input int row);
		return defaultOriginY + row * defaultCellSize + defaultCellSize / 2;
	endfunction

	// Decimal digits by repeated division, digit 0 lowest
	function automatic logic [4*bcdDigitCount-1:0] toBcd(input int magnitude);
		logic [4*bcdDigitCount-1:0] digits;
		digits = '0;
		for (int d = 0; d < bcdDigitCount; d++)
		begin
			digits[4*d +: 4] = 4'(magnitude % 10);
			magnitude = magnitude / 10;
		end
		return digits;
	endfunction

	// Keypad layout as seen on screen
	task automatic cellOf(input byte sym, output int col, output int row);
		case (sym)
			"7": begin col = 0; row = 0; end
			"8": begin col = 1; row = 0; end
			"9": begin col = 2; row = 0; end
			"*": begin col = 3; row = 0; end
			"/": begin col = 4; row = 0; end
			"4": begin col = 0; row = 1; end
			"5": begin col = 1; row = 1; end
			"6": begin col = 2; row = 1; end
			"+": begin col = 3; row = 1; end
			"-": begin col = 4; row = 1; end
			"1": begin col = 0; row = 2; end
			"2": begin col = 1; row = 2; end
			"3": begin col = 2; row = 2; end
			"=": begin col = 4; row = 2; end
			"0": begin col = 0; row = 3; end
			default: failRun($sformatf("key symbol %c is not on the keypad", sym));
		endcase
	endtask

	// Calculator rules applied to one key
	task automatic modelKey(input byte sym);
		int                           step;
		logic                         stepOverflow;
		logic                         stepDivZero;
		logic signed [valueWidth-1:0] wrapped;
		if (sym >= "0" && sym <= "9")
		begin
			if (modelDigits < maxEntryDigits)
			begin
				modelEntry  = modelEntry * 10 + (int'(sym) - 48);
				modelDigits = modelDigits + 1;
			end
		end
		else
		begin
			stepDivZero = 1'b0;
			case (modelOp)
				"+": step = modelAcc + modelEntry;
				"-": step = modelAcc - modelEntry;
				"*": step = modelAcc * modelEntry;
				"/":
				begin
					if (modelEntry == 0)
					begin
						stepDivZero = 1'b1;
						step        = 0;
					end
					else
						step = modelAcc / modelEntry;
				end
				default: step = modelEntry;
			endcase
			stepOverflow = step < minValue || step > maxValue;
			wrapped      = step[valueWidth-1:0];
			if (sym == "=")
			begin
				lastValue     = int'(wrapped);
				lastError     = modelOverflow || stepOverflow || modelDivZero || stepDivZero;
				modelAcc      = 0;
				modelOp       = " ";
				modelOverflow = 1'b0;
				modelDivZero  = 1'b0;
			end
			else
			begin
				modelAcc      = int'(wrapped);
				modelOp       = sym;
				modelOverflow = modelOverflow || stepOverflow;
				modelDivZero  = modelDivZero || stepDivZero;
			end
			modelEntry  = 0;
			modelDigits = 0;
		end
	endtask

	// Click at a pixel, hold, release and idle two cycles
	task automatic pressAt(input int x, input int y, input logic [2:0] button, input int cycles);
		@(posedge clk);
		xLocation <= xWidth'(x);
		yLocation <= yWidth'(y);
		clicked   <= button;
		repeat (cycles) @(posedge clk);
		clicked <= 3'b000;
		repeat (2) @(posedge clk);
	endtask

	task automatic pressKey(input byte sym);
		int col;
		int row;
		cellOf(sym, col, row);
		pressAt(centreX(col), centreY(row), 3'b001, 2);
		modelKey(sym);
	endtask

	task automatic enterSequence(input string seq);
		for (int i = 0; i < seq.len(); i++)
			pressKey(seq[i]);
	endtask

	task automatic waitForDisplay();
		do
			@(negedge clk);
		while (!displayValid);
	endtask

	task automatic expectResult(input int expValue, input logic expError);
		logic [4*bcdDigitCount-1:0] expDigits;
		logic                       expNegative;
		expDigits   = expError ? '0 : toBcd(expValue < 0 ? -expValue : expValue);
		expNegative = !expError && expValue < 0;
		waitForDisplay();
		assert (bcdDigits == expDigits)
		else
			failRun($sformatf("mismatch at %0t: bcdDigits expected %05h got %05h",
				$time, expDigits, bcdDigits));
		assert (negative == expNegative)
		else
			failRun($sformatf("mismatch at %0t: negative expected %b got %b",
				$time, expNegative, negative));
		assert (error == expError)
		else
			failRun($sformatf("mismatch at %0t: error expected %b got %b",
				$time, expError, error));
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic resetChecks();
		@(negedge clk);
		assert (!displayValid && !error && !negative && bcdDigits == '0)
		else
			failRun("outputs were not cleared by reset");
	endtask

	task automatic digitEntry();
		enterSequence("1234=");
		expectResult(1234, 1'b0);
		// Fifth digit must be dropped
		enterSequence("12345=");
		expectResult(1234, 1'b0);
	endtask

	task automatic chainedOperators();
		enterSequence("7+8*3=");
		expectResult(45, 1'b0);
		enterSequence("5-9=");
		expectResult(-4, 1'b0);
		enterSequence("0-7/2=");
		expectResult(-3, 1'b0);
		enterSequence("100/7=");
		expectResult(14, 1'b0);
	endtask

	task automatic errorFlags();
		enterSequence("9/0=");
		expectResult(0, 1'b1);
		enterSequence("9999*9999=");
		expectResult(0, 1'b1);
		enterSequence("2+3=");
		expectResult(5, 1'b0);
	endtask

	task automatic decodeGeometry();
		enterSequence("12+3");
		// Column border, row border, blank square, off the keypad
		pressAt(defaultOriginX + defaultCellSize, centreY(0), 3'b001, 2);
		pressAt(centreX(0), defaultOriginY + 2 * defaultCellSize, 3'b010, 2);
		pressAt(centreX(3), centreY(2), 3'b001, 2);
		pressAt(40, 30, 3'b001, 2);
		pressKey("=");
		expectResult(15, 1'b0);
		// Long hold on 5 counts once
		pressAt(centreX(1), centreY(1), 3'b100, holdCycles);
		modelKey("5");
		pressKey("=");
		expectResult(5, 1'b0);
	endtask

	task automatic randomOperands();
		int    a;
		int    b;
		int    pick;
		string opStr;
		for (int i = 0; i < 20; i++)
		begin
			pick = int'(nextRandom() % 4);
			case (pick)
				0: opStr = "+";
				1: opStr = "-";
				2: opStr = "*";
				default: opStr = "/";
			endcase
			// Smaller operands for multiply keep most products in range
			a = (pick == 2) ? int'(nextRandom() % 1000) : int'(nextRandom() % 10000);
			b = (pick == 2) ? int'(nextRandom() % 50) : int'(nextRandom() % 10000);
			enterSequence($sformatf("%0d%s%0d=", a, opStr, b));
			expectResult(lastValue, lastError);
		end
	endtask

	initial
	begin
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		resetChecks();
		digitEntry();
		chainedOperators();
		errorFlags();
		decodeGeometry();
		randomOperands();
		$display("All tests passed");
		$finish;
	end

endmodule

/* tb.f */
design/calcLayoutPkg.sv
design/calcKeyPkg.sv
design/keyIf.sv
design/resultIf.sv
design/clickDecoder.sv
design/calcExecute.sv
design/bcdConverter.sv
design/mouseCalculator.sv
tb/tbMouseCalculator.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tbMouseCalculator
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
